/* vlog.f */
source/lsq_pkg.sv
source/store_queue.sv
source/load_queue.sv
source/mem_arbiter.sv
source/completion_format.sv
source/lsq_top.sv
bench/dcache_model.sv
bench/lsq_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= lsq_tb
RTL_TOP ?= lsq_top
FLAGS ?= -j 0
SEED ?= 1
OBJ_DIR ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall --timing --assert -f vlog.f --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary --assert $(FLAGS) -f vlog.f --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)

/* bench/lsq_tb.sv */
`default_nettype none

module lsq_tb;
    import lsq_pkg::*;

    localparam int sq_depth = 8;
    localparam int lq_depth = 8;
    localparam int n_ops = 16;
    localparam int wait_limit = 300;

    // stimulus table: kind, funct3, address, store data, rob tag
    localparam logic tbl_store [n_ops] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1,
        1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0};
    localparam logic [2:0] tbl_f3 [n_ops] = '{lb, lbu, lh, lhu, lw, lb, lhu, sw,
        sb, sh, lw, lb, sb, lhu, sh, lh};
    localparam logic [31:0] tbl_addr [n_ops] = '{32'h41, 32'h43, 32'h52, 32'h60, 32'h74,
        32'h86, 32'h92, 32'h20, 32'h23, 32'h20, 32'h20, 32'h23, 32'h31, 32'h30, 32'h36, 32'h36};
    localparam logic [31:0] tbl_data [n_ops] = '{32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0,
        32'h0, 32'h1234_5678, 32'hffff_ff9c, 32'h0000_8001, 32'h0, 32'h0, 32'h0000_007e,
        32'h0, 32'h0000_abcd, 32'h0};
    localparam logic [4:0] tbl_rob [n_ops] = '{5'd1, 5'd2, 5'd3, 5'd4, 5'd5, 5'd6, 5'd7,
        5'd8, 5'd9, 5'd10, 5'd11, 5'd12, 5'd13, 5'd14, 5'd15, 5'd16};

    // loads that fill the load queue
    localparam logic [2:0] fill_f3 [lq_depth] = '{lb, lhu, lw, lbu, lh, lb, lw, lhu};
    localparam logic [31:0] fill_addr [lq_depth] = '{32'h81, 32'h86, 32'h88, 32'h8f,
        32'h92, 32'h97, 32'h98, 32'ha2};

    logic clk;
    logic rst;
    logic disp_load;
    logic disp_store;
    logic [2:0] disp_funct3;
    logic [4:0] disp_rob;
    logic [5:0] disp_pd;
    logic [2:0] load_idx;
    logic [2:0] store_idx;
    logic full;
    logic addr_valid;
    logic addr_is_store;
    logic [2:0] addr_idx;
    logic [31:0] addr;
    logic [31:0] store_data;
    logic [4:0] commit_rob;
    logic [31:0] d_addr;
    logic [3:0] d_rmask;
    logic [3:0] d_wmask;
    logic [31:0] d_wdata;
    logic d_resp;
    logic [31:0] d_rdata;
    logic done_valid;
    logic [4:0] done_rob;
    logic [5:0] done_pd;
    logic done_is_load;
    logic [31:0] done_value;

    // reference memory and expected completions by rob tag
    logic [31:0] ref_mem [64];
    logic exp_pending [32];
    logic exp_is_load [32];
    logic [5:0] exp_pd [32];
    logic [31:0] exp_value [32];
    logic [3:0] exp_rmask [32];
    // last read mask seen on the cache port
    logic [3:0] seen_rmask;
    int outstanding;
    int n_sent;
    int n_done;

    lsq_top #(
        .SQ_DEPTH (sq_depth),
        .LQ_DEPTH (lq_depth)
    ) dut_i (
        .clk (clk), .rst (rst),
        .disp_load (disp_load), .disp_store (disp_store), .disp_funct3 (disp_funct3),
        .disp_rob (disp_rob), .disp_pd (disp_pd),
        .load_idx (load_idx), .store_idx (store_idx), .full (full),
        .addr_valid (addr_valid), .addr_is_store (addr_is_store), .addr_idx (addr_idx),
        .addr (addr), .store_data (store_data), .commit_rob (commit_rob),
        .d_addr (d_addr), .d_rmask (d_rmask), .d_wmask (d_wmask), .d_wdata (d_wdata),
        .d_resp (d_resp), .d_rdata (d_rdata),
        .done_valid (done_valid), .done_rob (done_rob), .done_pd (done_pd),
        .done_is_load (done_is_load), .done_value (done_value)
    );

    dcache_model dcache_i (
        .clk (clk), .rst (rst),
        .d_addr (d_addr), .d_rmask (d_rmask), .d_wmask (d_wmask), .d_wdata (d_wdata),
        .d_resp (d_resp), .d_rdata (d_rdata)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [5:0] pd_of(input logic [4:0] rob);
        return {1'b0, rob} + 6'd17;
    endfunction

    // bits touched by an access of this size at offset zero
    function automatic logic [31:0] size_bits(input logic [2:0] f3);
        case (f3[1:0])
            2'b00: return 32'h0000_00ff;
            2'b01: return 32'h0000_ffff;
            default: return 32'hffff_ffff;
        endcase
    endfunction

    function automatic logic [31:0] load_result(input logic [2:0] f3, input logic [31:0] word,
        input logic [1:0] off);
        logic [31:0] shifted;
        shifted = word >> {off, 3'b000};
        case (f3)
            lb: return {{24{shifted[7]}}, shifted[7:0]};
            lbu: return shifted & 32'h0000_00ff;
            lh: return {{16{shifted[15]}}, shifted[15:0]};
            lhu: return shifted & 32'h0000_ffff;
            default: return word;
        endcase
    endfunction

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic wait_not_full;
        int cycles;
        cycles = 0;
        while (full && cycles < wait_limit)
        begin
            @(negedge clk);
            cycles++;
        end
        assert (!full) else stop_with_error("timed out waiting for full to drop");
    endtask

    task automatic wait_drain;
        int cycles;
        cycles = 0;
        while (outstanding != 0 && cycles < wait_limit)
        begin
            @(negedge clk);
            cycles++;
        end
        assert (outstanding == 0) else stop_with_error("timed out waiting for completions");
    endtask

    task automatic dispatch(input logic is_store, input logic [2:0] f3, input logic [4:0] rob,
        output logic [2:0] idx);
        wait_not_full();
        disp_load = !is_store;
        disp_store = is_store;
        disp_funct3 = f3;
        disp_rob = rob;
        disp_pd = pd_of(rob);
        idx = is_store ? store_idx : load_idx;
        n_sent++;
        @(negedge clk);
        disp_load = 1'b0;
        disp_store = 1'b0;
    endtask

    // expectation follows program order at the time the address is sent
    task automatic send_addr(input logic is_store, input logic [2:0] idx, input logic [2:0] f3,
        input logic [31:0] a, input logic [31:0] data, input logic [4:0] rob);
        logic [5:0] w;
        logic [31:0] lanes;
        w = a[7:2];
        lanes = size_bits(f3) << {a[1:0], 3'b000};
        if (is_store)
            ref_mem[w] = (ref_mem[w] & ~lanes) | ((data << {a[1:0], 3'b000}) & lanes);
        exp_pending[rob] = 1'b1;
        exp_is_load[rob] = !is_store;
        exp_pd[rob] = is_store ? 6'd0 : pd_of(rob);
        exp_value[rob] = is_store ? 32'd0 : load_result(f3, ref_mem[w], a[1:0]);
        exp_rmask[rob] = {|lanes[31:24], |lanes[23:16], |lanes[15:8], |lanes[7:0]};
        outstanding++;
        addr_valid = 1'b1;
        addr_is_store = is_store;
        addr_idx = idx;
        addr = a;
        store_data = data;
        @(negedge clk);
        addr_valid = 1'b0;
    endtask

    // completions are matched by tag, in any order
    always @(negedge clk)
    begin
        if (!rst && d_rmask != 4'd0)
            seen_rmask = d_rmask;
        if (!rst && done_valid)
        begin
            assert (exp_pending[done_rob])
                else stop_with_error($sformatf("FAIL %0t: unexpected completion for rob %0d",
                    $time, done_rob));
            assert (done_is_load == exp_is_load[done_rob] && done_pd == exp_pd[done_rob]
                && done_value == exp_value[done_rob])
                else stop_with_error($sformatf(
                    "FAIL %0t: rob %0d got load %0b pd %0d value %h, expected %0b %0d %h",
                    $time, done_rob, done_is_load, done_pd, done_value, exp_is_load[done_rob],
                    exp_pd[done_rob], exp_value[done_rob]));
            assert (!exp_is_load[done_rob] || seen_rmask == exp_rmask[done_rob])
                else stop_with_error($sformatf(
                    "FAIL %0t: rob %0d read mask %b, expected %b",
                    $time, done_rob, seen_rmask, exp_rmask[done_rob]));
            exp_pending[done_rob] = 1'b0;
            outstanding--;
            n_done++;
        end
    end

    initial
    begin
        logic [2:0] idx;
        logic [2:0] idx_list [lq_depth];
        disp_load = 1'b0;
        disp_store = 1'b0;
        disp_funct3 = 3'd0;
        disp_rob = 5'd0;
        disp_pd = 6'd0;
        addr_valid = 1'b0;
        addr_is_store = 1'b0;
        addr_idx = 3'd0;
        addr = 32'd0;
        store_data = 32'd0;
        commit_rob = 5'd0;
        seen_rmask = 4'd0;
        outstanding = 0;
        n_sent = 0;
        n_done = 0;
        for (int i = 0; i < 64; i++)
            ref_mem[i] = (32'(i) * 32'h0104_0917) ^ 32'hc3a5_6e19;
        for (int i = 0; i < 32; i++)
            exp_pending[i] = 1'b0;
        rst = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // preset loads, then stores each read back by a younger load
        for (int k = 0; k < n_ops; k++)
        begin
            if (tbl_store[k])
            begin
                wait_drain();
                commit_rob = tbl_rob[k];
            end
            dispatch(tbl_store[k], tbl_f3[k], tbl_rob[k], idx);
            send_addr(tbl_store[k], idx, tbl_f3[k], tbl_addr[k], tbl_data[k], tbl_rob[k]);
        end
        wait_drain();

        // store held until commit reaches its tag, younger load behind it
        dispatch(1'b1, sw, 5'd20, idx);
        send_addr(1'b1, idx, sw, 32'h44, 32'hdead_beef, 5'd20);
        dispatch(1'b0, lw, 5'd21, idx);
        send_addr(1'b0, idx, lw, 32'h44, 32'h0, 5'd21);
        repeat (40) @(negedge clk);
        assert (outstanding == 2)
            else stop_with_error($sformatf("FAIL %0t: %0d held operations completed early",
                $time, 2 - outstanding));
        commit_rob = 5'd20;
        wait_drain();

        // fill the load queue without addresses
        for (int k = 0; k < lq_depth; k++)
            dispatch(1'b0, fill_f3[k], 5'(24 + k), idx_list[k]);
        assert (full)
            else stop_with_error($sformatf("FAIL %0t: full low with %0d loads waiting",
                $time, lq_depth));
        send_addr(1'b0, idx_list[0], fill_f3[0], fill_addr[0], 32'h0, 5'd24);
        wait_not_full();
        // the rest get addresses in reverse order
        for (int k = lq_depth - 1; k > 0; k--)
            send_addr(1'b0, idx_list[k], fill_f3[k], fill_addr[k], 32'h0, 5'(24 + k));
        wait_drain();

        if (outstanding == 0 && n_done == n_sent)
        begin
            $display("TEST OK");
            $finish;
        end
        else
            stop_with_error("completion count does not match the dispatched operations");
    end

endmodule

`default_nettype wire

/* bench/dcache_model.sv */
`default_nettype none

module dcache_model (
    input  logic clk,
    input  logic rst,
    input  logic [31:0] d_addr,
    input  logic [3:0] d_rmask,
    input  logic [3:0] d_wmask,
    input  logic [31:0] d_wdata,
    output logic d_resp,
    output logic [31:0] d_rdata
);
    logic [31:0] mem [64];
    logic busy;
    logic [1:0] delay;
    logic [5:0] word_idx;
    integer seed;

    assign word_idx = d_addr[7:2];

    // word i holds a pattern spread over all index bits
    initial
    begin
        seed = 32'h403e6d42;
        for (int i = 0; i < 64; i++)
            mem[i] = (32'(i) * 32'h0104_0917) ^ 32'hc3a5_6e19;
    end

    always @(posedge clk)
    begin
        if (rst)
        begin
            busy <= 1'b0;
            delay <= '0;
            d_resp <= 1'b0;
            d_rdata <= '0;
        end
        else
        begin
            d_resp <= 1'b0;
            // a new request shows up as a nonzero mask
            if (!busy && !d_resp && (|d_rmask || |d_wmask))
            begin
                busy <= 1'b1;
                delay <= 2'($unsigned($random(seed)) % 4);
            end
            else if (busy)
            begin
                if (delay == 2'd0)
                begin
                    busy <= 1'b0;
                    d_resp <= 1'b1;
                    d_rdata <= mem[word_idx];
                    for (int b = 0; b < 4; b++)
                    begin
                        if (d_wmask[b])
                            mem[word_idx][8*b +: 8] <= d_wdata[8*b +: 8];
                    end
                end
                else
                    delay <= delay - 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* source/lsq_top.sv */
`default_nettype none

module lsq_top #(
    parameter int SQ_DEPTH = 8,
    parameter int LQ_DEPTH = 8,
    localparam int idx_w = (SQ_DEPTH > LQ_DEPTH) ? $clog2(SQ_DEPTH) : $clog2(LQ_DEPTH)
) (
    input  logic clk,
    input  logic rst,

    // dispatch
    input  logic disp_load,
    input  logic disp_store,
    input  logic [2:0] disp_funct3,
    input  logic [lsq_pkg::rob_tag_width-1:0] disp_rob,
    input  logic [lsq_pkg::phys_reg_width-1:0] disp_pd,
    output logic [$clog2(LQ_DEPTH)-1:0] load_idx,
    output logic [$clog2(SQ_DEPTH)-1:0] store_idx,
    output logic full,

    // address adder
    input  logic addr_valid,
    input  logic addr_is_store,
    input  logic [idx_w-1:0] addr_idx,
    input  logic [31:0] addr,
    input  logic [31:0] store_data,

    // commit
    input  logic [lsq_pkg::rob_tag_width-1:0] commit_rob,

    // data cache
    output logic [31:0] d_addr,
    output logic [3:0] d_rmask,
    output logic [3:0] d_wmask,
    output logic [31:0] d_wdata,
    input  logic d_resp,
    input  logic [31:0] d_rdata,

    // completion broadcast
    output logic done_valid,
    output logic [lsq_pkg::rob_tag_width-1:0] done_rob,
    output logic [lsq_pkg::phys_reg_width-1:0] done_pd,
    output logic done_is_load,
    output logic [31:0] done_value
);
    import lsq_pkg::*;

    logic sq_full;
    logic lq_full;

    logic lq_ready;
    logic [31:0] lq_addr;
    logic [2:0] lq_funct3;
    logic [rob_tag_width-1:0] lq_rob;
    logic [phys_reg_width-1:0] lq_pd;
    logic lq_take;

    logic sq_ready;
    logic [31:0] sq_addr;
    logic [2:0] sq_funct3;
    logic [31:0] sq_data;
    logic [rob_tag_width-1:0] sq_rob;
    logic sq_pop;

    logic resp_valid;
    logic resp_is_load;
    logic [2:0] resp_funct3;
    logic [1:0] resp_offset;
    logic [rob_tag_width-1:0] resp_rob;
    logic [phys_reg_width-1:0] resp_pd;
    logic [31:0] resp_data;

    assign full = sq_full | lq_full;

    store_queue #(
        .SQ_DEPTH (SQ_DEPTH)
    ) store_queue_i (
        .clk           (clk),
        .rst           (rst),
        .disp_store    (disp_store),
        .disp_funct3   (disp_funct3),
        .disp_rob      (disp_rob),
        .addr_valid    (addr_valid),
        .addr_is_store (addr_is_store),
        .addr_idx      (addr_idx[$clog2(SQ_DEPTH)-1:0]),
        .addr          (addr),
        .store_data    (store_data),
        .sq_pop        (sq_pop),
        .store_idx     (store_idx),
        .sq_full       (sq_full),
        .sq_ready      (sq_ready),
        .sq_addr       (sq_addr),
        .sq_funct3     (sq_funct3),
        .sq_data       (sq_data),
        .sq_rob        (sq_rob)
    );

    load_queue #(
        .LQ_DEPTH (LQ_DEPTH),
        .SQ_DEPTH (SQ_DEPTH)
    ) load_queue_i (
        .clk           (clk),
        .rst           (rst),
        .disp_load     (disp_load),
        .disp_store    (disp_store),
        .disp_funct3   (disp_funct3),
        .disp_rob      (disp_rob),
        .disp_pd       (disp_pd),
        .addr_valid    (addr_valid),
        .addr_is_store (addr_is_store),
        .addr_idx      (addr_idx[$clog2(LQ_DEPTH)-1:0]),
        .addr          (addr),
        .sq_pop        (sq_pop),
        .lq_take       (lq_take),
        .load_idx      (load_idx),
        .lq_full       (lq_full),
        .lq_ready      (lq_ready),
        .lq_addr       (lq_addr),
        .lq_funct3     (lq_funct3),
        .lq_rob        (lq_rob),
        .lq_pd         (lq_pd)
    );

    mem_arbiter mem_arbiter_i (
        .clk          (clk),
        .rst          (rst),
        .commit_rob   (commit_rob),
        .d_resp       (d_resp),
        .d_rdata      (d_rdata),
        .lq_ready     (lq_ready),
        .lq_addr      (lq_addr),
        .lq_funct3    (lq_funct3),
        .lq_rob       (lq_rob),
        .lq_pd        (lq_pd),
        .sq_ready     (sq_ready),
        .sq_addr      (sq_addr),
        .sq_funct3    (sq_funct3),
        .sq_data      (sq_data),
        .sq_rob       (sq_rob),
        .lq_take      (lq_take),
        .sq_pop       (sq_pop),
        .d_addr       (d_addr),
        .d_rmask      (d_rmask),
        .d_wmask      (d_wmask),
        .d_wdata      (d_wdata),
        .resp_valid   (resp_valid),
        .resp_is_load (resp_is_load),
        .resp_funct3  (resp_funct3),
        .resp_offset  (resp_offset),
        .resp_rob     (resp_rob),
        .resp_pd      (resp_pd),
        .resp_data    (resp_data)
    );

    completion_format completion_format_i (
        .clk          (clk),
        .rst          (rst),
        .resp_valid   (resp_valid),
        .resp_is_load (resp_is_load),
        .resp_funct3  (resp_funct3),
        .resp_offset  (resp_offset),
        .resp_rob     (resp_rob),
        .resp_pd      (resp_pd),
        .resp_data    (resp_data),
        .done_valid   (done_valid),
        .done_rob     (done_rob),
        .done_pd      (done_pd),
        .done_is_load (done_is_load),
        .done_value   (done_value)
    );

endmodule

`default_nettype wire

/* source/completion_format.sv */
`default_nettype none

module completion_format (
    input  logic clk,
    input  logic rst,
    input  logic resp_valid,
    input  logic resp_is_load,
    input  logic [2:0] resp_funct3,
    input  logic [1:0] resp_offset,
    input  logic [lsq_pkg::rob_tag_width-1:0] resp_rob,
    input  logic [lsq_pkg::phys_reg_width-1:0] resp_pd,
    input  logic [31:0] resp_data,
    output logic done_valid,
    output logic [lsq_pkg::rob_tag_width-1:0] done_rob,
    output logic [lsq_pkg::phys_reg_width-1:0] done_pd,
    output logic done_is_load,
    output logic [31:0] done_value
);
    import lsq_pkg::*;

    mem_word_u rdata;
    logic [7:0] byte_sel;
    logic [15:0] half_sel;
    logic [31:0] load_value;

    assign rdata.word = resp_data;
    assign byte_sel = rdata.byte_lane[resp_offset];
    // halfword lane from the upper offset bit
    assign half_sel = rdata.half_lane[resp_offset[1]];

    always_comb
    begin
        case (resp_funct3)
            lb: load_value = {{24{byte_sel[7]}}, byte_sel};
            lbu: load_value = {24'b0, byte_sel};
            lh: load_value = {{16{half_sel[15]}}, half_sel};
            lhu: load_value = {16'b0, half_sel};
            lw: load_value = rdata.word;
            default: load_value = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            done_valid <= 1'b0;
        else
            done_valid <= resp_valid;
    end

    // stores report no destination and no value
    always_ff @(posedge clk)
    begin
        if (resp_valid)
        begin
            done_rob <= resp_rob;
            done_is_load <= resp_is_load;
            done_pd <= resp_is_load ? resp_pd : '0;
            done_value <= resp_is_load ? load_value : '0;
        end
    end

endmodule

`default_nettype wire

/* source/mem_arbiter.sv */
`default_nettype none

module mem_arbiter (
    input  logic clk,
    input  logic rst,
    input  logic [lsq_pkg::rob_tag_width-1:0] commit_rob,
    input  logic d_resp,
    input  logic [31:0] d_rdata,
    input  logic lq_ready,
    input  logic [31:0] lq_addr,
    input  logic [2:0] lq_funct3,
    input  logic [lsq_pkg::rob_tag_width-1:0] lq_rob,
    input  logic [lsq_pkg::phys_reg_width-1:0] lq_pd,
    input  logic sq_ready,
    input  logic [31:0] sq_addr,
    input  logic [2:0] sq_funct3,
    input  logic [31:0] sq_data,
    input  logic [lsq_pkg::rob_tag_width-1:0] sq_rob,
    output logic lq_take,
    output logic sq_pop,
    output logic [31:0] d_addr,
    output logic [3:0] d_rmask,
    output logic [3:0] d_wmask,
    output logic [31:0] d_wdata,
    output logic resp_valid,
    output logic resp_is_load,
    output logic [2:0] resp_funct3,
    output logic [1:0] resp_offset,
    output logic [lsq_pkg::rob_tag_width-1:0] resp_rob,
    output logic [lsq_pkg::phys_reg_width-1:0] resp_pd,
    output logic [31:0] resp_data
);
    import lsq_pkg::*;

    typedef enum logic [1:0] {
        st_load_chk,
        st_load_wait,
        st_store_chk,
        st_store_wait
    } state_t;

    state_t state;
    state_t state_next;
    logic store_go;
    logic waiting;
    logic [3:0] rmask_new;
    logic [3:0] wmask_new;
    mem_word_u wdata_new;

    logic [2:0] req_funct3;
    logic [1:0] req_offset;
    logic [rob_tag_width-1:0] req_rob;
    logic [phys_reg_width-1:0] req_pd;

    // funct3[1:0] gives the access size for loads and stores alike
    function automatic logic [3:0] lane_mask(input logic [2:0] funct3, input logic [1:0] offset);
        case (funct3[1:0])
            2'b00: lane_mask = 4'b0001 << offset;
            2'b01: lane_mask = 4'b0011 << {offset[1], 1'b0};
            default: lane_mask = 4'b1111;
        endcase
    endfunction

    // only the committing store may write
    assign store_go = sq_ready && (sq_rob == commit_rob);
    assign lq_take = (state == st_load_chk) && lq_ready;
    assign sq_pop = (state == st_store_chk) && store_go;
    assign waiting = (state == st_load_wait) || (state == st_store_wait);
    assign rmask_new = lane_mask(lq_funct3, lq_addr[1:0]);
    assign wmask_new = lane_mask(sq_funct3, sq_addr[1:0]);

    // put store data into its lanes
    always_comb
    begin
        wdata_new.word = '0;
        case (sq_funct3)
            sb: wdata_new.byte_lane[sq_addr[1:0]] = sq_data[7:0];
            sh: wdata_new.half_lane[sq_addr[1]] = sq_data[15:0];
            default: wdata_new.word = sq_data;
        endcase
    end

    always_comb
    begin
        state_next = state;
        case (state)
            st_load_chk: state_next = lq_ready ? st_load_wait : st_store_chk;
            st_store_chk: state_next = store_go ? st_store_wait : st_load_chk;
            // after a response the other side gets the next turn
            st_load_wait:
                if (d_resp)
                    state_next = st_store_chk;
            st_store_wait:
                if (d_resp)
                    state_next = st_load_chk;
            default: state_next = st_load_chk;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= st_load_chk;
            d_rmask <= '0;
            d_wmask <= '0;
        end
        else
        begin
            state <= state_next;
            if (lq_take)
                d_rmask <= rmask_new;
            else if (sq_pop)
                d_wmask <= wmask_new;
            else if (d_resp)
            begin
                d_rmask <= '0;
                d_wmask <= '0;
            end
        end
    end

    // request payload held until the response
    always_ff @(posedge clk)
    begin
        if (lq_take)
        begin
            d_addr <= {lq_addr[31:2], 2'b00};
            req_funct3 <= lq_funct3;
            req_offset <= lq_addr[1:0];
            req_rob <= lq_rob;
            req_pd <= lq_pd;
        end
        else if (sq_pop)
        begin
            d_addr <= {sq_addr[31:2], 2'b00};
            d_wdata <= wdata_new.word;
            req_funct3 <= sq_funct3;
            req_offset <= sq_addr[1:0];
            req_rob <= sq_rob;
        end
    end

    assign resp_valid = d_resp && waiting;
    assign resp_is_load = (state == st_load_wait);
    assign resp_funct3 = req_funct3;
    assign resp_offset = req_offset;
    assign resp_rob = req_rob;
    assign resp_pd = req_pd;
    assign resp_data = d_rdata;

    a_resp_in_wait: assert property (@(posedge clk) disable iff (rst) d_resp |-> waiting)
        else $error("cache response with no request outstanding");

endmodule

`default_nettype wire

/* source/load_queue.sv */
`default_nettype none

module load_queue #(
    parameter int LQ_DEPTH = 8,
    parameter int SQ_DEPTH = 8,
    localparam int aw = $clog2(LQ_DEPTH),
    localparam int cw = $clog2(SQ_DEPTH + 1)
) (
    input  logic clk,
    input  logic rst,
    input  logic disp_load,
    input  logic disp_store,
    input  logic [2:0] disp_funct3,
    input  logic [lsq_pkg::rob_tag_width-1:0] disp_rob,
    input  logic [lsq_pkg::phys_reg_width-1:0] disp_pd,
    input  logic addr_valid,
    input  logic addr_is_store,
    input  logic [aw-1:0] addr_idx,
    input  logic [31:0] addr,
    input  logic sq_pop,
    input  logic lq_take,
    output logic [aw-1:0] load_idx,
    output logic lq_full,
    output logic lq_ready,
    output logic [31:0] lq_addr,
    output logic [2:0] lq_funct3,
    output logic [lsq_pkg::rob_tag_width-1:0] lq_rob,
    output logic [lsq_pkg::phys_reg_width-1:0] lq_pd
);
    import lsq_pkg::*;

    logic [LQ_DEPTH-1:0] valid;
    logic [LQ_DEPTH-1:0] addr_rdy;
    logic [cw-1:0] older [LQ_DEPTH];
    logic [2:0] funct3_q [LQ_DEPTH];
    logic [rob_tag_width-1:0] rob_q [LQ_DEPTH];
    logic [phys_reg_width-1:0] pd_q [LQ_DEPTH];
    logic [31:0] addr_q [LQ_DEPTH];

    // mirrors store queue occupancy
    logic [cw-1:0] st_count;
    logic [cw-1:0] new_count;
    logic [aw-1:0] sel;
    logic push;
    logic store_push;
    logic addr_write;

    assign lq_full = &valid;
    assign push = disp_load && !lq_full;
    // a saturated count means the store queue is full and drops the strobe
    assign store_push = disp_store && (st_count != cw'(SQ_DEPTH));
    assign new_count = sq_pop ? st_count - 1'b1 : st_count;
    assign addr_write = addr_valid && !addr_is_store;

    // scan downward so the lowest index wins
    always_comb
    begin
        load_idx = '0;
        sel = '0;
        lq_ready = 1'b0;
        for (int i = LQ_DEPTH - 1; i >= 0; i--)
        begin
            if (!valid[i])
                load_idx = aw'(i);
            if (valid[i] && addr_rdy[i] && older[i] == '0)
            begin
                sel = aw'(i);
                lq_ready = 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            valid <= '0;
            addr_rdy <= '0;
            st_count <= '0;
        end
        else
        begin
            st_count <= st_count + cw'(store_push) - cw'(sq_pop);
            if (lq_take)
                valid[sel] <= 1'b0;
            if (push)
            begin
                valid[load_idx] <= 1'b1;
                addr_rdy[load_idx] <= 1'b0;
            end
            if (addr_write)
                addr_rdy[addr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        // each retiring store releases one older-store count
        for (int i = 0; i < LQ_DEPTH; i++)
        begin
            if (sq_pop && older[i] != '0)
                older[i] <= older[i] - 1'b1;
        end
        if (push)
        begin
            older[load_idx] <= new_count;
            funct3_q[load_idx] <= disp_funct3;
            rob_q[load_idx] <= disp_rob;
            pd_q[load_idx] <= disp_pd;
        end
        if (addr_write)
            addr_q[addr_idx] <= addr;
    end

    assign lq_addr = addr_q[sel];
    assign lq_funct3 = funct3_q[sel];
    assign lq_rob = rob_q[sel];
    assign lq_pd = pd_q[sel];

    a_addr_to_valid: assert property (@(posedge clk) disable iff (rst)
        addr_write |-> valid[addr_idx])
        else $error("load address written to an empty slot");

endmodule

`default_nettype wire

/* source/store_queue.sv */
`default_nettype none

module store_queue #(
    parameter int SQ_DEPTH = 8,
    localparam int aw = $clog2(SQ_DEPTH)
) (
    input  logic clk,
    input  logic rst,
    input  logic disp_store,
    input  logic [2:0] disp_funct3,
    input  logic [lsq_pkg::rob_tag_width-1:0] disp_rob,
    input  logic addr_valid,
    input  logic addr_is_store,
    input  logic [aw-1:0] addr_idx,
    input  logic [31:0] addr,
    input  logic [31:0] store_data,
    input  logic sq_pop,
    output logic [aw-1:0] store_idx,
    output logic sq_full,
    output logic sq_ready,
    output logic [31:0] sq_addr,
    output logic [2:0] sq_funct3,
    output logic [31:0] sq_data,
    output logic [lsq_pkg::rob_tag_width-1:0] sq_rob
);
    import lsq_pkg::*;

    // pointers carry a wrap bit above the index
    logic [aw:0] head;
    logic [aw:0] tail;
    logic [aw-1:0] head_idx;
    logic sq_empty;
    logic push;
    logic addr_write;

    logic [SQ_DEPTH-1:0] addr_rdy;
    logic [2:0] funct3_q [SQ_DEPTH];
    logic [rob_tag_width-1:0] rob_q [SQ_DEPTH];
    logic [31:0] addr_q [SQ_DEPTH];
    logic [31:0] data_q [SQ_DEPTH];

    assign head_idx = head[aw-1:0];
    assign store_idx = tail[aw-1:0];
    assign sq_empty = (head == tail);
    assign sq_full = (head[aw] != tail[aw]) && (head_idx == store_idx);
    assign push = disp_store && !sq_full;
    assign addr_write = addr_valid && addr_is_store;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            head <= '0;
            tail <= '0;
            addr_rdy <= '0;
        end
        else
        begin
            if (push)
            begin
                tail <= tail + 1'b1;
                addr_rdy[store_idx] <= 1'b0;
            end
            if (sq_pop)
                head <= head + 1'b1;
            // address may land in the same cycle as a later push
            if (addr_write)
                addr_rdy[addr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            funct3_q[store_idx] <= disp_funct3;
            rob_q[store_idx] <= disp_rob;
        end
        if (addr_write)
        begin
            addr_q[addr_idx] <= addr;
            data_q[addr_idx] <= store_data;
        end
    end

    // head is offered once its address is known
    assign sq_ready = !sq_empty && addr_rdy[head_idx];
    assign sq_addr = addr_q[head_idx];
    assign sq_funct3 = funct3_q[head_idx];
    assign sq_data = data_q[head_idx];
    assign sq_rob = rob_q[head_idx];

    a_no_push_full: assert property (@(posedge clk) disable iff (rst) disp_store |-> !sq_full)
        else $error("store dispatched into a full store queue");

    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) sq_pop |-> !sq_empty)
        else $error("store queue popped while empty");

endmodule

`default_nettype wire

/* source/lsq_pkg.sv */
`default_nettype none

package lsq_pkg;

    // tag and register widths
    localparam int rob_tag_width = 5;
    localparam int phys_reg_width = 6;

    // RV32I load funct3 codes
    localparam logic [2:0] lb = 3'b000;
    localparam logic [2:0] lh = 3'b001;
    localparam logic [2:0] lw = 3'b010;
    localparam logic [2:0] lbu = 3'b100;
    localparam logic [2:0] lhu = 3'b101;

    // RV32I store funct3 codes
    localparam logic [2:0] sb = 3'b000;
    localparam logic [2:0] sh = 3'b001;
    localparam logic [2:0] sw = 3'b010;

    // one memory word, seen whole or by lanes
    // lane 0 is the least significant byte or halfword
    typedef union packed {
        logic [31:0] word;
        logic [3:0][7:0] byte_lane;
        logic [1:0][15:0] half_lane;
    } mem_word_u;

endpackage

`default_nettype wire
